// File: include/ooo_chan_settings.svh
/*
 * Out-of-order channel settings
 * Field widths, FIFO depths and thresholds, wait station count
 * and the delay window of the wait stations
 */
`ifndef OOO_CHAN_SETTINGS_SVH
`define OOO_CHAN_SETTINGS_SVH

// Payload and header field widths
`define OOO_DATA_W          64
`define OOO_ADDR_W          32
`define OOO_TID_W           16
`define OOO_MDATA_W         16

// Input and output FIFOs, visible to the outside
`define OOO_VIS_DEPTH       32
`define OOO_VIS_FULL_TH     28
`define OOO_OUT_ALMFULL_TH  26

// Per-channel lanes
`define OOO_LANE_DEPTH      16
`define OOO_LANE_FULL_TH    12

// Wait stations and their delay window, in cycles
`define OOO_NUM_WS          16
`define OOO_WS_ALMFULL      13
`define OOO_DELAY_MIN       15
`define OOO_DELAY_MAX       60

`endif

// File: src/ooo_chan_pkg.sv
/*
 * Out-of-order channel types
 * Channel and request codes, transmit and response headers,
 * and the records carried by the lane and output FIFOs
 */
`default_nettype none

`include "ooo_chan_settings.svh"

package ooo_chan_pkg;

   // VA means any channel, resolved at steering
   typedef enum logic [1:0] {
      VA  = 2'd0,
      VL0 = 2'd1,
      VH0 = 2'd2,
      VH1 = 2'd3
   } vc_e;

   typedef enum logic {RDLINE = 1'b0, WRLINE = 1'b1} reqtype_e;
   typedef enum logic {RD_RESP = 1'b0, WR_RESP = 1'b1} resptype_e;

   // Lines minus one, and line index inside a request
   typedef logic [1:0] len_t;
   typedef logic [1:0] clnum_t;

   typedef struct packed {
      vc_e                     vc;
      reqtype_e                reqtype;
      len_t                    len;
      logic [`OOO_ADDR_W-1:0]  addr;
      logic [`OOO_MDATA_W-1:0] mdata;
   } tx_hdr_t;

   typedef struct packed {
      vc_e                     vc;
      resptype_e               resptype;
      clnum_t                  clnum;
      logic [`OOO_MDATA_W-1:0] mdata;
   } rx_hdr_t;

   // Input and lane FIFO payload
   typedef struct packed {
      logic [`OOO_TID_W-1:0]  tid;
      logic [`OOO_DATA_W-1:0] data;
      tx_hdr_t                tx_hdr;
   } req_t;

   // One output line
   typedef struct packed {
      logic [`OOO_TID_W-1:0]  tid;
      logic [`OOO_DATA_W-1:0] data;
      rx_hdr_t                rx_hdr;
      tx_hdr_t                tx_hdr;
   } out_entry_t;

   typedef logic [$clog2(`OOO_NUM_WS)-1:0] slot_t;
   typedef logic [`OOO_NUM_WS-1:0]         slot_vec_t;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
/*
 * Synchronous FIFO
 * Circular buffer with a head visible before the pop,
 * fill count, empty flag and almost-full threshold
 */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
   parameter type item_t     = logic [7:0],
   parameter int  DEPTH      = 16,
   parameter int  ALMFULL_TH = 12
) (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       push_i,
   input  wire item_t                      item_i,
   input  wire logic                       pop_i,
   output item_t                           head_o,
   output logic                            empty_o,
   output logic                            almfull_o,
   output logic [$clog2(DEPTH+1)-1:0]      count_o
);

   localparam int AW = $clog2(DEPTH);

   item_t           mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic            do_push;
   logic            do_pop;

   // Push on a full FIFO and pop on an empty one are dropped
   assign do_push = push_i && (count_o != DEPTH);
   assign do_pop  = pop_i && (count_o != 0);

   // Storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= item_i;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_o <= count_o + 1'b1;
            2'b01:   count_o <= count_o - 1'b1;
            default: count_o <= count_o;
         endcase
      end
   end

   // Head seen without a pop
   assign head_o    = mem[rd_ptr];
   assign empty_o   = (count_o == 0);
   assign almfull_o = (count_o >= ALMFULL_TH);

endmodule

`default_nettype wire

// File: src/chan_ctrl.sv
/*
 * Channel controller
 * Steers input requests onto the VL0, VH0 and VH1 lanes, pops the
 * lanes in rotation into free wait stations, and hands ready
 * stations to the line breakout, releasing them when it is done
 */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_chan_settings.svh"

module chan_ctrl (
   input  wire logic                         clk,
   input  wire logic                         rst,
   // Input FIFO
   input  wire ooo_chan_pkg::req_t           in_head_i,
   input  wire logic                         in_empty_i,
   output logic                              in_pop_o,
   // Lanes, index 0 is VL0
   output logic [2:0]                        lane_push_o,
   output ooo_chan_pkg::req_t                lane_req_o,
   input  wire ooo_chan_pkg::req_t [2:0]     lane_head_i,
   input  wire logic [2:0]                   lane_empty_i,
   input  wire logic [2:0]                   lane_almfull_i,
   // Wait station pool
   output logic                              ws_wr_o,
   output ooo_chan_pkg::slot_t               ws_slot_o,
   output ooo_chan_pkg::req_t                ws_req_o,
   input  wire ooo_chan_pkg::slot_vec_t      ws_busy_i,
   input  wire ooo_chan_pkg::slot_vec_t      ws_ready_i,
   output ooo_chan_pkg::slot_t               ws_rd_slot_o,
   input  wire ooo_chan_pkg::req_t           ws_rd_req_i,
   output logic                              ws_release_o,
   // Line breakout
   output logic                              bk_start_o,
   output ooo_chan_pkg::req_t                bk_req_o,
   input  wire logic                         bk_busy_i,
   input  wire logic                         bk_done_i,
   input  wire logic                         out_almfull_i
);

   localparam int NWS = `OOO_NUM_WS;
   localparam int SW  = $clog2(NWS);

   logic [1:0]            last_lane;
   logic [1:0]            va_lane;
   logic                  va_ok;
   logic [1:0]            tgt_lane;
   logic                  tgt_ok;
   logic [1:0]            pop_lane;
   logic                  ws_almfull;
   ooo_chan_pkg::slot_t   push_ptr;
   ooo_chan_pkg::slot_t   free_slot;
   logic                  free_ok;
   ooo_chan_pkg::slot_t   pop_ptr;
   ooo_chan_pkg::slot_t   rdy_slot;
   logic                  rdy_ok;
   ooo_chan_pkg::slot_t   cur_slot;

   // First set bit at or after ptr, wrapping, with a found flag on top
   function automatic logic [SW:0] first_set(input ooo_chan_pkg::slot_vec_t vec,
                                             input ooo_chan_pkg::slot_t ptr);
      logic [SW:0] res;
      int          idx;
      res = '0;
      for (int k = NWS - 1; k >= 0; k--) begin
         idx = (int'(ptr) + k) % NWS;
         if (vec[idx]) begin
            res = {1'b1, SW'(idx)};
         end
      end
      return res;
   endfunction

   ////////////////////////////////////////
   // Steering
   ////////////////////////////////////////

   always_comb begin
      int idx;
      va_lane    = 2'd0;
      va_ok      = 1'b0;
      // Lane after the last VA pick that is not almost full
      for (int k = 3; k >= 1; k--) begin
         idx = (int'(last_lane) + k) % 3;
         if (!lane_almfull_i[idx]) begin
            va_lane = 2'(idx);
            va_ok   = 1'b1;
         end
      end
      lane_req_o = in_head_i;
      if (in_head_i.tx_hdr.vc == ooo_chan_pkg::VA) begin
         tgt_lane             = va_lane;
         tgt_ok               = va_ok;
         lane_req_o.tx_hdr.vc = ooo_chan_pkg::vc_e'(va_lane + 2'd1);
      end else begin
         // Named channel keeps its lane
         tgt_lane = in_head_i.tx_hdr.vc - 2'd1;
         tgt_ok   = !lane_almfull_i[tgt_lane];
      end
   end

   assign in_pop_o    = !in_empty_i && tgt_ok;
   assign lane_push_o = in_pop_o ? (3'b001 << tgt_lane) : 3'b000;

   ////////////////////////////////////////
   // Lane pop into wait stations
   ////////////////////////////////////////

   assign ws_almfull            = ($countones(ws_busy_i) >= `OOO_WS_ALMFULL);
   assign {free_ok, free_slot}  = first_set(~ws_busy_i, push_ptr);

   // One lane looked at per cycle
   assign ws_wr_o   = !lane_empty_i[pop_lane] && !ws_almfull && free_ok;
   assign ws_slot_o = free_slot;
   assign ws_req_o  = lane_head_i[pop_lane];

   ////////////////////////////////////////
   // Release to breakout
   ////////////////////////////////////////

   assign {rdy_ok, rdy_slot} = first_set(ws_ready_i, pop_ptr);

   // Held output stops new starts only
   assign bk_start_o   = rdy_ok && !bk_busy_i && !out_almfull_i;
   assign bk_req_o     = ws_rd_req_i;
   // Read index follows the active slot so done frees the right one
   assign ws_rd_slot_o = bk_busy_i ? cur_slot : rdy_slot;
   assign ws_release_o = bk_done_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         last_lane <= 2'd2;
         pop_lane  <= 2'd0;
         push_ptr  <= '0;
         pop_ptr   <= '0;
      end else begin
         pop_lane <= (pop_lane == 2'd2) ? 2'd0 : pop_lane + 2'd1;
         if (in_pop_o && (in_head_i.tx_hdr.vc == ooo_chan_pkg::VA)) begin
            last_lane <= va_lane;
         end
         if (ws_wr_o) begin
            push_ptr <= free_slot + 1'b1;
         end
         if (bk_start_o) begin
            pop_ptr <= rdy_slot + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bk_start_o) begin
         cur_slot <= rdy_slot;
      end
   end

endmodule

`default_nettype wire

// File: src/wait_station_pool.sv
/*
 * Wait station pool
 * Holds requests for a pseudo-random delay. Each station runs
 * idle, countdown, done-ready and popped; an LFSR folded into the
 * delay window loads the counter when a station is written
 */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_chan_settings.svh"

module wait_station_pool #(
   parameter int NUM_WS = `OOO_NUM_WS
) (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       wr_i,
   input  wire ooo_chan_pkg::slot_t        wr_slot_i,
   input  wire ooo_chan_pkg::req_t         wr_req_i,
   input  wire logic                       release_i,
   input  wire ooo_chan_pkg::slot_t        release_slot_i,
   input  wire ooo_chan_pkg::slot_t        rd_slot_i,
   output ooo_chan_pkg::req_t              rd_req_o,
   output ooo_chan_pkg::slot_vec_t         busy_o,
   output ooo_chan_pkg::slot_vec_t         ready_o
);

   localparam int SPAN  = `OOO_DELAY_MAX - `OOO_DELAY_MIN + 1;
   localparam int RAW_W = $clog2(SPAN);
   localparam int DLY_W = $clog2(`OOO_DELAY_MAX + 1);

   typedef enum logic [1:0] {
      WS_IDLE,
      WS_COUNT,
      WS_READY,
      WS_POPPED
   } ws_state_e;

   ooo_chan_pkg::req_t   rec_mem [NUM_WS];
   ws_state_e            state   [NUM_WS];
   logic [DLY_W-1:0]     dly_cnt [NUM_WS];
   logic [15:0]          lfsr;
   logic [RAW_W-1:0]     raw;
   logic [DLY_W-1:0]     new_delay;

   ////////////////////////////////////////
   // Delay source
   ////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11, free running
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= 16'hace1;
      end else begin
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
   end

   // Fold low bits into the window, raw stays below twice the span
   assign raw       = lfsr[RAW_W-1:0];
   assign new_delay = (raw >= SPAN) ? DLY_W'(raw - SPAN + `OOO_DELAY_MIN)
                                    : DLY_W'(raw + `OOO_DELAY_MIN);

   ////////////////////////////////////////
   // Records and station FSMs
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_i) begin
         rec_mem[wr_slot_i] <= wr_req_i;
      end
   end

   assign rd_req_o = rec_mem[rd_slot_i];

   for (genvar i = 0; i < NUM_WS; i++) begin : g_ws
      always_ff @(posedge clk) begin
         if (rst) begin
            state[i]   <= WS_IDLE;
            dly_cnt[i] <= '0;
         end else begin
            case (state[i])
               WS_IDLE: begin
                  if (wr_i && (wr_slot_i == i)) begin
                     state[i]   <= WS_COUNT;
                     dly_cnt[i] <= new_delay;
                  end
               end
               // Ready after exactly the loaded number of cycles
               WS_COUNT: begin
                  if (dly_cnt[i] == 1) begin
                     state[i] <= WS_READY;
                  end
                  dly_cnt[i] <= dly_cnt[i] - 1'b1;
               end
               WS_READY: begin
                  if (release_i && (release_slot_i == i)) begin
                     state[i] <= WS_POPPED;
                  end
               end
               default: state[i] <= WS_IDLE;
            endcase
         end
      end

      assign busy_o[i]  = (state[i] != WS_IDLE);
      assign ready_o[i] = (state[i] == WS_READY);
   end

endmodule

`default_nettype wire

// File: src/line_breakout.sv
/*
 * Line breakout
 * Expands a released request into one output entry per cache
 * line, one per cycle, each with its response header
 */
`timescale 1ns/1ns
`default_nettype none

module line_breakout (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    start_i,
   input  wire ooo_chan_pkg::req_t      req_i,
   output logic                         busy_o,
   output logic                         done_o,
   output logic                         out_push_o,
   output ooo_chan_pkg::out_entry_t     out_entry_o
);

   ooo_chan_pkg::req_t     rec;
   ooo_chan_pkg::clnum_t   clnum;

   // Latched record
   always_ff @(posedge clk) begin
      if (start_i && !busy_o) begin
         rec <= req_i;
      end
   end

   // Line counter, len plus one cycles back to back
   always_ff @(posedge clk) begin
      if (rst) begin
         busy_o <= 1'b0;
         clnum  <= '0;
      end else if (!busy_o) begin
         if (start_i) begin
            busy_o <= 1'b1;
            clnum  <= '0;
         end
      end else if (done_o) begin
         busy_o <= 1'b0;
      end else begin
         clnum <= clnum + 1'b1;
      end
   end

   assign done_o     = busy_o && (clnum == rec.tx_hdr.len);
   assign out_push_o = busy_o;

   // Entry for the current line
   always_comb begin
      out_entry_o.tid         = rec.tid;
      out_entry_o.data        = rec.data;
      out_entry_o.tx_hdr      = rec.tx_hdr;
      out_entry_o.tx_hdr.addr = rec.tx_hdr.addr + clnum;
      out_entry_o.rx_hdr.vc   = rec.tx_hdr.vc;
      out_entry_o.rx_hdr.resptype = (rec.tx_hdr.reqtype == ooo_chan_pkg::WRLINE) ?
                                    ooo_chan_pkg::WR_RESP : ooo_chan_pkg::RD_RESP;
      out_entry_o.rx_hdr.clnum = clnum;
      out_entry_o.rx_hdr.mdata = rec.tx_hdr.mdata;
   end

endmodule

`default_nettype wire

// File: src/ooo_chan_top.sv
/*
 * Out-of-order request channel
 * Input FIFO, three channel lanes, wait stations with random
 * latency, line breakout and an output FIFO drained by a read strobe
 */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_chan_settings.svh"

module ooo_chan_top (
   input  wire logic                        clk,
   input  wire logic                        rst,
   // Request side
   input  wire ooo_chan_pkg::tx_hdr_t       hdr_i,
   input  wire logic [`OOO_DATA_W-1:0]      data_i,
   input  wire logic                        write_en_i,
   // Response side
   output ooo_chan_pkg::tx_hdr_t            tx_hdr_o,
   output ooo_chan_pkg::rx_hdr_t            rx_hdr_o,
   output logic [`OOO_DATA_W-1:0]           data_o,
   output logic [`OOO_TID_W-1:0]            tid_o,
   output logic                             valid_o,
   input  wire logic                        read_en_i,
   // Status
   output logic                             empty_o,
   output logic                             full_o
);

   logic [`OOO_TID_W-1:0]           tid_cnt;
   ooo_chan_pkg::req_t              in_req;
   ooo_chan_pkg::req_t              in_head;
   logic                            in_empty;
   logic                            in_almfull;
   logic                            in_pop;
   logic [2:0]                      lane_push;
   logic [2:0]                      lane_pop;
   ooo_chan_pkg::req_t              lane_req;
   ooo_chan_pkg::req_t [2:0]        lane_head;
   logic [2:0]                      lane_empty;
   logic [2:0]                      lane_almfull;
   logic                            ws_wr;
   ooo_chan_pkg::slot_t             ws_slot;
   ooo_chan_pkg::req_t              ws_req;
   ooo_chan_pkg::slot_vec_t         ws_busy;
   ooo_chan_pkg::slot_vec_t         ws_ready;
   ooo_chan_pkg::slot_t             ws_rd_slot;
   ooo_chan_pkg::req_t              ws_rd_req;
   logic                            ws_release;
   logic                            bk_start;
   ooo_chan_pkg::req_t              bk_req;
   logic                            bk_busy;
   logic                            bk_done;
   logic                            out_push;
   ooo_chan_pkg::out_entry_t        out_entry;
   ooo_chan_pkg::out_entry_t        out_head;
   ooo_chan_pkg::out_entry_t        out_q;
   logic                            out_empty;
   logic                            out_almfull;
   logic                            out_pop;

   ////////////////////////////////////////
   // Input stage
   ////////////////////////////////////////

   // Tracking ID counts accepted writes
   always_ff @(posedge clk) begin
      if (rst) begin
         tid_cnt <= '0;
      end else if (write_en_i) begin
         tid_cnt <= tid_cnt + 1'b1;
      end
   end

   assign in_req = '{tid: tid_cnt, data: data_i, tx_hdr: hdr_i};

   sync_fifo #(
      .item_t     (ooo_chan_pkg::req_t),
      .DEPTH      (`OOO_VIS_DEPTH),
      .ALMFULL_TH (`OOO_VIS_FULL_TH)
   ) i_in_fifo (
      .clk, .rst,
      .push_i (write_en_i), .item_i (in_req), .pop_i (in_pop),
      .head_o (in_head), .empty_o (in_empty), .almfull_o (in_almfull), .count_o ()
   );

   // Held high through reset
   always_ff @(posedge clk) begin
      if (rst) begin
         full_o <= 1'b1;
      end else begin
         full_o <= in_almfull;
      end
   end

   ////////////////////////////////////////
   // Lanes VL0, VH0, VH1
   ////////////////////////////////////////

   for (genvar k = 0; k < 3; k++) begin : g_lane
      // Lane k only holds requests on channel k plus one
      assign lane_pop[k] = ws_wr && (ws_req.tx_hdr.vc == ooo_chan_pkg::vc_e'(k + 1));

      sync_fifo #(
         .item_t     (ooo_chan_pkg::req_t),
         .DEPTH      (`OOO_LANE_DEPTH),
         .ALMFULL_TH (`OOO_LANE_FULL_TH)
      ) i_lane_fifo (
         .clk, .rst,
         .push_i (lane_push[k]), .item_i (lane_req), .pop_i (lane_pop[k]),
         .head_o (lane_head[k]), .empty_o (lane_empty[k]),
         .almfull_o (lane_almfull[k]), .count_o ()
      );
   end

   chan_ctrl i_ctrl (
      .clk, .rst,
      .in_head_i (in_head), .in_empty_i (in_empty), .in_pop_o (in_pop),
      .lane_push_o (lane_push), .lane_req_o (lane_req), .lane_head_i (lane_head),
      .lane_empty_i (lane_empty), .lane_almfull_i (lane_almfull),
      .ws_wr_o (ws_wr), .ws_slot_o (ws_slot), .ws_req_o (ws_req),
      .ws_busy_i (ws_busy), .ws_ready_i (ws_ready),
      .ws_rd_slot_o (ws_rd_slot), .ws_rd_req_i (ws_rd_req), .ws_release_o (ws_release),
      .bk_start_o (bk_start), .bk_req_o (bk_req), .bk_busy_i (bk_busy),
      .bk_done_i (bk_done), .out_almfull_i (out_almfull)
   );

   wait_station_pool #(.NUM_WS(`OOO_NUM_WS)) i_pool (
      .clk, .rst,
      .wr_i (ws_wr), .wr_slot_i (ws_slot), .wr_req_i (ws_req),
      .release_i (ws_release), .release_slot_i (ws_rd_slot),
      .rd_slot_i (ws_rd_slot), .rd_req_o (ws_rd_req),
      .busy_o (ws_busy), .ready_o (ws_ready)
   );

   line_breakout i_breakout (
      .clk, .rst,
      .start_i (bk_start), .req_i (bk_req), .busy_o (bk_busy), .done_o (bk_done),
      .out_push_o (out_push), .out_entry_o (out_entry)
   );

   ////////////////////////////////////////
   // Output stage
   ////////////////////////////////////////

   sync_fifo #(
      .item_t     (ooo_chan_pkg::out_entry_t),
      .DEPTH      (`OOO_VIS_DEPTH),
      .ALMFULL_TH (`OOO_OUT_ALMFULL_TH)
   ) i_out_fifo (
      .clk, .rst,
      .push_i (out_push), .item_i (out_entry), .pop_i (out_pop),
      .head_o (out_head), .empty_o (out_empty), .almfull_o (out_almfull), .count_o ()
   );

   // One read strobe on a non-empty FIFO gives one valid pulse
   assign out_pop = read_en_i && !out_empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= out_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (out_pop) begin
         out_q <= out_head;
      end
   end

   assign tx_hdr_o = out_q.tx_hdr;
   assign rx_hdr_o = out_q.rx_hdr;
   assign data_o   = out_q.data;
   assign tid_o    = out_q.tid;
   assign empty_o  = out_empty;

endmodule

`default_nettype wire

// File: testbench/tb_ooo_chan.sv
/*
 * Testbench for the out-of-order request channel
 * Drives requests, drains response lines with the read strobe,
 * and scores every line by tracking ID and line index
 */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_chan_settings.svh"

module tb_ooo_chan;

   localparam int MAX_REQ    = 128;
   // Room for 75 requests of at most DELAY_MAX + 8 cycles each and a wide margin
   localparam int MAX_CYCLES = 20000;
   localparam int PAT_LEN    = 1024;

   logic                        clk;
   logic                        rst;
   ooo_chan_pkg::tx_hdr_t       hdr_i;
   logic [`OOO_DATA_W-1:0]      data_i;
   logic                        write_en_i;
   logic                        read_en_i;
   ooo_chan_pkg::tx_hdr_t       tx_hdr_o;
   ooo_chan_pkg::rx_hdr_t       rx_hdr_o;
   logic [`OOO_DATA_W-1:0]      data_o;
   logic [`OOO_TID_W-1:0]       tid_o;
   logic                        valid_o;
   logic                        empty_o;
   logic                        full_o;

   // Scoreboard indexed by tid * 4 + clnum
   ooo_chan_pkg::out_entry_t    exp_mem [MAX_REQ*4];
   logic [MAX_REQ*4-1:0]        exp_live   = '0;
   logic [MAX_REQ*4-1:0]        exp_any_vc = '0;
   int                          pending    = 0;
   int                          next_tid   = 0;
   int                          errors     = 0;
   ooo_chan_pkg::vc_e           va_last;

   string                       cur_test   = "startup";
   int                          cycle      = 0;
   logic                        contig_mode = 1'b0;
   logic                        rand_read   = 1'b0;
   logic                        read_hold   = 1'b0;
   logic [PAT_LEN-1:0]          read_pat;
   logic [`OOO_TID_W-1:0]       last_tid   = '0;
   ooo_chan_pkg::clnum_t        last_cl    = '0;
   int                          last_cycle = 0;

   ooo_chan_top i_dut (
      .clk, .rst,
      .hdr_i, .data_i, .write_en_i,
      .tx_hdr_o, .rx_hdr_o, .data_o, .tid_o, .valid_o,
      .read_en_i, .empty_o, .full_o
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////
   // Checks and failure exit
   ////////////////////////////////////////

   task automatic end_in_failure();
      errors++;
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_equal(input string field, input logic [159:0] expected,
                              input logic [159:0] actual);
      assert (expected === actual) else begin
         $display("Fail %s %s expected %h actual %h", cur_test, field, expected, actual);
         end_in_failure();
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond === 1'b1) else begin
         $display("Error in %s: %s", cur_test, what);
         end_in_failure();
      end
   endtask

   // Hang guard
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
         end_in_failure();
      end
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // VA rotation order VL0, VH0, VH1
   function automatic ooo_chan_pkg::vc_e next_va_channel(input ooo_chan_pkg::vc_e last);
      ooo_chan_pkg::vc_e nxt;
      case (last)
         ooo_chan_pkg::VL0: nxt = ooo_chan_pkg::VH0;
         ooo_chan_pkg::VH0: nxt = ooo_chan_pkg::VH1;
         default:           nxt = ooo_chan_pkg::VL0;
      endcase
      return nxt;
   endfunction

   // One output line of a request on its resolved channel
   function automatic ooo_chan_pkg::out_entry_t expected_line(
         input logic [`OOO_TID_W-1:0] tid, input logic [`OOO_DATA_W-1:0] data,
         input ooo_chan_pkg::tx_hdr_t hdr, input ooo_chan_pkg::vc_e vc, input int cl);
      ooo_chan_pkg::out_entry_t e;
      e.tid              = tid;
      e.data             = data;
      e.tx_hdr           = hdr;
      e.tx_hdr.vc        = vc;
      e.tx_hdr.addr      = hdr.addr + `OOO_ADDR_W'(cl);
      e.rx_hdr.vc        = vc;
      e.rx_hdr.resptype  = (hdr.reqtype == ooo_chan_pkg::WRLINE) ?
                           ooo_chan_pkg::WR_RESP : ooo_chan_pkg::RD_RESP;
      e.rx_hdr.clnum     = ooo_chan_pkg::clnum_t'(cl);
      e.rx_hdr.mdata     = hdr.mdata;
      return e;
   endfunction

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Loose VA means the channel depends on lane fill and is not predicted
   task automatic send_request(input ooo_chan_pkg::vc_e vc, input ooo_chan_pkg::reqtype_e rt,
                               input ooo_chan_pkg::len_t len,
                               input logic [`OOO_ADDR_W-1:0] addr,
                               input logic [`OOO_MDATA_W-1:0] mdata,
                               input logic [`OOO_DATA_W-1:0] data, input logic loose_va);
      ooo_chan_pkg::tx_hdr_t hdr;
      ooo_chan_pkg::vc_e     exp_vc;
      int                    base;
      check_true(next_tid < MAX_REQ, "more requests than the scoreboard holds");
      hdr.vc      = vc;
      hdr.reqtype = rt;
      hdr.len     = len;
      hdr.addr    = addr;
      hdr.mdata   = mdata;
      exp_vc      = vc;
      if ((vc == ooo_chan_pkg::VA) && !loose_va) begin
         exp_vc  = next_va_channel(va_last);
         va_last = exp_vc;
      end
      base = next_tid * 4;
      for (int cl = 0; cl <= int'(len); cl++) begin
         exp_mem[base + cl]    = expected_line(next_tid[`OOO_TID_W-1:0], data, hdr, exp_vc, cl);
         exp_live[base + cl]   = 1'b1;
         exp_any_vc[base + cl] = loose_va && (vc == ooo_chan_pkg::VA);
         pending++;
      end
      // Source writes only while full is low
      @(negedge clk);
      while (full_o) begin
         @(negedge clk);
      end
      @(posedge clk);
      hdr_i      <= hdr;
      data_i     <= data;
      write_en_i <= 1'b1;
      next_tid++;
      @(posedge clk);
      write_en_i <= 1'b0;
   endtask

   task automatic send_random_request();
      ooo_chan_pkg::vc_e        vc;
      ooo_chan_pkg::reqtype_e   rt;
      ooo_chan_pkg::len_t       len;
      logic [`OOO_ADDR_W-1:0]   addr;
      logic [`OOO_MDATA_W-1:0]  mdata;
      logic [`OOO_DATA_W-1:0]   data;
      vc    = ooo_chan_pkg::vc_e'(2'($urandom % 4));
      rt    = ooo_chan_pkg::reqtype_e'(1'($urandom % 2));
      len   = ooo_chan_pkg::len_t'($urandom % 4);
      addr  = $urandom;
      mdata = 16'($urandom);
      data  = {$urandom, $urandom};
      send_request(vc, rt, len, addr, mdata, data, 1'b1);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic wait_for_drain();
      while (pending != 0) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);
      check_true(empty_o, "output FIFO not empty after all lines arrived");
   endtask

   // Read strobe held high or taken from the random gap pattern
   always @(posedge clk) begin
      if (rand_read) begin
         read_en_i <= read_pat[cycle % PAT_LEN];
      end else begin
         read_en_i <= read_hold;
      end
   end

   ////////////////////////////////////////
   // Compare process
   ////////////////////////////////////////

   always @(negedge clk) begin : compare
      int                        idx;
      ooo_chan_pkg::out_entry_t  exp_e;
      ooo_chan_pkg::clnum_t      cl;
      if (valid_o === 1'b1) begin
         cl = rx_hdr_o.clnum;
         check_true(tid_o < MAX_REQ, $sformatf("output tid %0d out of range", tid_o));
         idx = int'(tid_o) * 4 + int'(cl);
         check_true(exp_live[idx], $sformatf("unexpected output tid %0d line %0d", tid_o, cl));
         exp_e = exp_mem[idx];
         // Channel of a loose VA only has to be concrete
         if (exp_any_vc[idx]) begin
            check_true(rx_hdr_o.vc != ooo_chan_pkg::VA, "VA request left without a channel");
            exp_e.rx_hdr.vc = rx_hdr_o.vc;
            exp_e.tx_hdr.vc = rx_hdr_o.vc;
         end
         check_equal("tid", exp_e.tid, tid_o);
         check_equal("data", exp_e.data, data_o);
         check_equal("tx_hdr", exp_e.tx_hdr, tx_hdr_o);
         check_equal("rx_hdr", exp_e.rx_hdr, rx_hdr_o);
         // Lines of one record stay together
         if (cl != 0) begin
            check_true((last_tid == tid_o) && (last_cl == cl - 1),
                       $sformatf("line %0d of tid %0d not after its previous line", cl, tid_o));
            if (contig_mode) begin
               check_true(last_cycle == cycle - 1,
                          $sformatf("gap before line %0d of tid %0d", cl, tid_o));
            end
         end
         exp_live[idx] = 1'b0;
         pending--;
         last_tid   = tid_o;
         last_cl    = cl;
         last_cycle = cycle;
      end
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      rst        = 1'b1;
      hdr_i      = '0;
      data_i     = '0;
      write_en_i = 1'b0;
      read_en_i  = 1'b0;
      va_last    = ooo_chan_pkg::VH1;
      void'($urandom(694));
      for (int i = 0; i < PAT_LEN; i++) begin
         read_pat[i] = (($urandom % 3) != 0);
      end

      // Reset held for 10 rising edges
      cur_test = "reset_state";
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         if (i == 9) begin
            rst <= 1'b0;
         end
         @(negedge clk);
         check_equal("valid_o", 1'b0, valid_o);
         check_equal("empty_o", 1'b1, empty_o);
         check_equal("full_o", 1'b1, full_o);
      end
      @(negedge clk);
      check_equal("valid_o", 1'b0, valid_o);
      check_equal("empty_o", 1'b1, empty_o);
      check_equal("full_o", 1'b0, full_o);
      read_hold = 1'b1;

      cur_test = "single_line";
      send_request(ooo_chan_pkg::VL0, ooo_chan_pkg::RDLINE, 2'd0, 32'h1000_0040,
                   16'h00a1, 64'h0123_4567_89ab_cdef, 1'b0);
      send_request(ooo_chan_pkg::VH0, ooo_chan_pkg::WRLINE, 2'd0, 32'h2000_0080,
                   16'h00b2, 64'hfedc_ba98_7654_3210, 1'b0);
      wait_for_drain();

      // Read strobe stays high here
      cur_test = "multi_line";
      @(posedge clk);
      contig_mode = 1'b1;
      for (int l = 0; l < 4; l++) begin
         send_request(ooo_chan_pkg::vc_e'(2'(l % 3 + 1)), ooo_chan_pkg::reqtype_e'(1'(l % 2)),
                      ooo_chan_pkg::len_t'(l), $urandom, 16'($urandom),
                      {$urandom, $urandom}, 1'b0);
      end
      wait_for_drain();
      @(posedge clk);
      contig_mode = 1'b0;

      // Named requests between the VAs leave the rotation alone
      cur_test = "vc_assign";
      for (int v = 0; v < 9; v++) begin
         send_request((v % 2 == 0 || v > 5) ? ooo_chan_pkg::VA :
                      ooo_chan_pkg::vc_e'(2'((v / 2) % 3 + 1)),
                      ooo_chan_pkg::RDLINE, 2'd0, $urandom, 16'(v), {$urandom, $urandom}, 1'b0);
         idle_cycles(5);
      end
      wait_for_drain();

      cur_test = "burst_backpressure";
      @(negedge clk);
      rand_read = 1'b1;
      repeat (60) begin
         send_random_request();
      end
      @(negedge clk);
      rand_read = 1'b0;
      wait_for_drain();

      @(negedge clk);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
src/ooo_chan_pkg.sv
src/sync_fifo.sv
src/chan_ctrl.sv
src/wait_station_pool.sv
src/line_breakout.sv
src/ooo_chan_top.sv
testbench/tb_ooo_chan.sv

// File: Bender.yml
package:
  name: ooo_chan

sources:
  - include_dirs:
      - include
    files:
      - src/ooo_chan_pkg.sv
      - src/sync_fifo.sv
      - src/chan_ctrl.sv
      - src/wait_station_pool.sv
      - src/line_breakout.sv
      - src/ooo_chan_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_ooo_chan.sv
